// File: compile.f
+incdir+hdl
hdl/hdr_pkg.sv
hdl/apb_hdr_regs.sv
hdl/hdr_engine.sv
hdl/ccc_frame_gen.sv
hdl/ddr_frame_gen.sv
hdl/hdr_frame_out.sv
hdl/i3c_hdr_top.sv
tests/hdr_assertions.sv
tests/tb_i3c_hdr.sv

// File: tests/tb_i3c_hdr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the I3C HDR slice: APB commands, frame model and compare
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hdr_macros.svh"

module tb_i3c_hdr;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int N_RANDOM   = 20;
  // directed commands plus random ones
  localparam int N_STEPS    = 8 + N_RANDOM;
  localparam int WD_CYCLES  = N_STEPS * 200 + RST_CYCLES;

  logic        i_sys_clk;
  logic        i_sys_rst_n;
  logic        i_psel;
  logic        i_penable;
  logic        i_pwrite;
  logic [3:0]  i_paddr;
  logic [31:0] i_pwdata;
  logic [31:0] o_prdata;
  logic        o_pready;
  logic        o_pslverr;
  logic        o_frm_valid;
  logic [19:0] o_frm_data;
  logic        i_frm_ready;
  logic        o_irq;

  logic [19:0] exp_q[$];
  logic [19:0] exp_frm;
  logic        unexpected;
  logic [1:0]  ready_mode;
  logic        irq_prev;
  int          irq_rises;
  int          err_cnt;
  int          tests_ok;
  int          tests_bad;

  i3c_hdr_top u_i3c_hdr_top (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_frm_valid (o_frm_valid),
    .o_frm_data  (o_frm_data),
    .i_frm_ready (i_frm_ready),
    .o_irq       (o_irq)
  );

  always #(CLK_PERIOD / 2) i_sys_clk = ~i_sys_clk;

  // odd bits into the upper parity bit, even bits inverted into the lower
  function automatic logic [1:0] frame_parity(input logic [15:0] payload);
    logic odd_x;
    logic even_x;
    odd_x  = 1'b0;
    even_x = 1'b0;
    for (int i = 0; i < 16; i++) begin
      if (i % 2 == 1) begin
        odd_x = odd_x ^ payload[i];
      end else begin
        even_x = even_x ^ payload[i];
      end
    end
    return {odd_x, ~even_x};
  endfunction

  function automatic logic [19:0] make_frame(input logic [1:0] pre, input logic [15:0] payload);
    return {pre, payload, frame_parity(payload)};
  endfunction

  // expected frames of one command, appended to exp_q
  function automatic void hdr_expect_frames(input logic [2:0] mode, input logic cp,
                                            input logic toc, input logic [15:0] cmd,
                                            input logic [15:0] data);
    if (mode != `HDR_MODE_DDR) begin
      return;
    end
    exp_q.push_back(make_frame(`HDR_PRE_CMD, cmd));
    if (cp && cmd[15]) begin
      // direct CCC carries the defining byte and the low data byte
      exp_q.push_back(make_frame(`HDR_PRE_DATA, {cmd[7:0], data[7:0]}));
    end else if (!cp && !cmd[15]) begin
      exp_q.push_back(make_frame(`HDR_PRE_DATA, data));
    end
    exp_q.push_back(make_frame(toc ? `HDR_PRE_EXIT : `HDR_PRE_RESTART, 16'd0));
  endfunction

  function automatic logic [31:0] ctrl_word(input logic [2:0] mode, input logic cp,
                                            input logic toc, input logic start);
    logic [31:0] w;
    w = 32'd0;
    w[`HDR_CTRL_MODE_LSB +: 3]  = mode;
    w[`HDR_CTRL_CP_BIT]         = cp;
    w[`HDR_CTRL_TOC_BIT]        = toc;
    w[`HDR_CTRL_START_BIT]      = start;
    return w;
  endfunction

  function automatic logic [31:0] status_word(input logic busy, input logic done,
                                              input logic err);
    logic [31:0] w;
    w = 32'd0;
    w[`HDR_STAT_BUSY_BIT] = busy;
    w[`HDR_STAT_DONE_BIT] = done;
    w[`HDR_STAT_ERR_BIT]  = err;
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR: %0t ns %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    @(posedge i_sys_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= wr;
    i_paddr   <= addr;
    i_pwdata  <= wdata;
    @(posedge i_sys_clk);
    i_penable <= 1'b1;
    @(posedge i_sys_clk);
    rdata  = o_prdata;
    slverr = o_pslverr;
    // no wait states, so ready is high in every access phase
    check_value("o_pready", 32'd1, {31'd0, o_pready});
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, wdata, rdata, slverr);
    check_value("o_pslverr", 32'd0, {31'd0, slverr});
  endtask

  task automatic apb_read_check(input string name, input logic [3:0] addr,
                                input logic [31:0] exp);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b0, addr, 32'd0, rdata, slverr);
    check_value("o_pslverr", 32'd0, {31'd0, slverr});
    check_value(name, exp, rdata);
  endtask

  task automatic wait_irq(input int max_cycles);
    int n;
    n = 0;
    // the start has cleared the old done by now
    @(posedge i_sys_clk);
    check_value("o_irq", 32'd0, {31'd0, o_irq});
    while (!o_irq && n < max_cycles) begin
      @(posedge i_sys_clk);
      n++;
    end
    assert (o_irq) else begin
      $display("o_irq did not rise within %0d cycles of the start", max_cycles);
      err_cnt++;
    end
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge i_sys_clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%0d expected frames never reached o_frm_data", exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
  endtask

  task automatic run_cmd(input logic [2:0] mode, input logic cp, input logic toc,
                         input logic [15:0] cmd, input logic [15:0] data);
    apb_write(`HDR_REG_CMD, {16'd0, cmd});
    apb_write(`HDR_REG_DATA, {16'd0, data});
    hdr_expect_frames(mode, cp, toc, cmd, data);
    apb_write(`HDR_REG_CTRL, ctrl_word(mode, cp, toc, 1'b1));
    wait_irq(200);
    wait_drained(200);
    apb_read_check("STATUS", `HDR_REG_STATUS,
                   status_word(1'b0, 1'b1, mode != `HDR_MODE_DDR));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // PHY ready: always, random stalls, or held off
  always @(posedge i_sys_clk) begin
    case (ready_mode)
      2'd1:    i_frm_ready <= ($urandom % 4) != 0;
      2'd2:    i_frm_ready <= 1'b0;
      default: i_frm_ready <= 1'b1;
    endcase
  end

  // every accepted output frame against the model queue
  always @(posedge i_sys_clk) begin
    if (i_sys_rst_n && o_frm_valid && i_frm_ready) begin
      unexpected = (exp_q.size() == 0);
      assert (!unexpected) else begin
        $display("frame %h left the DUT at %0t ns with none expected", o_frm_data, $time);
        err_cnt++;
      end
      if (!unexpected) begin
        exp_frm = exp_q.pop_front();
        assert (o_frm_data === exp_frm) else begin
          $display("ERROR: %0t ns o_frm_data expected %h actual %h",
                   $time, exp_frm, o_frm_data);
          err_cnt++;
        end
      end
    end
  end

  always @(posedge i_sys_clk) begin
    irq_prev <= o_irq;
    if (o_irq && !irq_prev) begin
      irq_rises <= irq_rises + 1;
    end
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles", WD_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int test_errs;
    int irq_base;
    int asrt_fails;
    void'($urandom(84501));
    i_sys_clk   = 1'b0;
    i_sys_rst_n = 1'b0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = 4'd0;
    i_pwdata    = 32'd0;
    i_frm_ready = 1'b1;
    ready_mode  = 2'd0;
    irq_prev    = 1'b0;
    irq_rises   = 0;
    err_cnt     = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    repeat (RST_CYCLES) @(posedge i_sys_clk);
    i_sys_rst_n <= 1'b1;

    test_errs = err_cnt;
    apb_write(`HDR_REG_CMD, 32'h0000_A5C3);
    apb_read_check("CMD", `HDR_REG_CMD, 32'h0000_A5C3);
    apb_write(`HDR_REG_DATA, 32'hFFFF_1E2D);
    apb_read_check("DATA", `HDR_REG_DATA, 32'h0000_1E2D);
    apb_write(`HDR_REG_CTRL, ctrl_word(3'd6, 1'b1, 1'b1, 1'b0));
    apb_read_check("CTRL", `HDR_REG_CTRL, ctrl_word(3'd6, 1'b1, 1'b1, 1'b0));
    // START is write-only, so it must read back clear
    run_cmd(3'd2, 1'b1, 1'b0, 16'h0101, 16'h0202);
    apb_read_check("CTRL", `HDR_REG_CTRL, ctrl_word(3'd2, 1'b1, 1'b0, 1'b0));
    begin
      logic [31:0] rdata;
      logic        slverr;
      apb_access(1'b0, 4'h6, 32'd0, rdata, slverr);
      check_value("o_pslverr", 32'd1, {31'd0, slverr});
    end
    finish_test("apb access", test_errs);

    test_errs = err_cnt;
    run_cmd(3'd6, 1'b1, 1'b1, 16'h0712, 16'h3344);
    run_cmd(3'd6, 1'b1, 1'b1, 16'h9A34, 16'h55C7);
    finish_test("ccc broadcast and direct", test_errs);

    test_errs = err_cnt;
    run_cmd(3'd6, 1'b0, 1'b0, 16'h2468, 16'hB00F);
    run_cmd(3'd6, 1'b0, 1'b0, 16'hC2F1, 16'h1111);
    finish_test("ddr write and read", test_errs);

    test_errs = err_cnt;
    ready_mode <= 2'd1;
    for (int i = 0; i < N_RANDOM; i++) begin
      run_cmd(3'd6, $urandom % 2, $urandom % 2, $urandom, $urandom);
    end
    ready_mode <= 2'd0;
    finish_test("random back-pressure", test_errs);

    test_errs = err_cnt;
    run_cmd(3'd5, 1'b0, 1'b1, 16'h4321, 16'h8765);
    // err must clear on the next good command
    run_cmd(3'd6, 1'b0, 1'b1, 16'h8A10, 16'h0000);
    finish_test("bad mode", test_errs);

    test_errs = err_cnt;
    ready_mode <= 2'd2;
    apb_write(`HDR_REG_CMD, 32'h0000_1234);
    apb_write(`HDR_REG_DATA, 32'h0000_5A5A);
    hdr_expect_frames(3'd6, 1'b0, 1'b0, 16'h1234, 16'h5A5A);
    irq_base = irq_rises;
    apb_write(`HDR_REG_CTRL, ctrl_word(3'd6, 1'b0, 1'b0, 1'b1));
    apb_write(`HDR_REG_CTRL, ctrl_word(3'd6, 1'b0, 1'b0, 1'b1));
    apb_read_check("STATUS", `HDR_REG_STATUS, status_word(1'b1, 1'b0, 1'b0));
    ready_mode <= 2'd0;
    wait_irq(200);
    wait_drained(200);
    repeat (50) @(posedge i_sys_clk);
    check_value("o_irq rises", 32'd1, irq_rises - irq_base);
    finish_test("start while busy", test_errs);

    repeat (5) @(posedge i_sys_clk);
    asrt_fails = u_i3c_hdr_top.u_assertions.fail_cnt;
    $display("tests ok %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_ok, tests_bad, err_cnt, asrt_fails);
    if (err_cnt == 0 && asrt_fails == 0 && tests_bad == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tests/hdr_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDR controller checks: output hold, launch exclusivity, reset state
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hdr_assertions (
  input logic        i_sys_clk,
  input logic        i_sys_rst_n,
  input logic        i_frm_valid,
  input logic [19:0] i_frm_data,
  input logic        i_frm_ready,
  input logic        i_ccc_en,
  input logic        i_ddr_en
);

  int hold_fails = 0;
  int excl_fails = 0;
  int rst_fails  = 0;
  int fail_cnt;

  assign fail_cnt = hold_fails + excl_fails + rst_fails;

  // frame must not move while the PHY stalls
  a_frm_hold: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    (i_frm_valid && !i_frm_ready) |=> (i_frm_valid && $stable(i_frm_data)))
    else begin
      $error("o_frm_data or o_frm_valid changed under back-pressure");
      hold_fails++;
    end

  a_one_launch: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    !(i_ccc_en && i_ddr_en))
    else begin
      $error("CCC and DDR generators launched together");
      excl_fails++;
    end

  a_rst_idle: assert property (@(posedge i_sys_clk) $rose(i_sys_rst_n) |-> !i_frm_valid)
    else begin
      $error("o_frm_valid high right after reset release");
      rst_fails++;
    end

endmodule

// reaches output stage ports and sequencer enables through the top level
bind i3c_hdr_top hdr_assertions u_assertions (
  .i_sys_clk   (i_sys_clk),
  .i_sys_rst_n (i_sys_rst_n),
  .i_frm_valid (o_frm_valid),
  .i_frm_data  (o_frm_data),
  .i_frm_ready (i_frm_ready),
  .i_ccc_en    (ccc_en),
  .i_ddr_en    (ddr_en)
);

// File: hdl/i3c_hdr_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I3C HDR controller slice: APB registers, sequencer, generators, output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hdr_macros.svh"

module i3c_hdr_top import hdr_pkg::*; (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`HDR_APB_AW-1:0] i_paddr,
  input  logic [31:0]            i_pwdata,
  output logic [31:0]            o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr,
  output logic                   o_frm_valid,
  output logic [`HDR_FRM_W-1:0]  o_frm_data,
  input  logic                   i_frm_ready,
  output logic                   o_irq
);

  logic [2:0]    mode;
  logic          cp;
  logic          toc;
  hdr_cmd_u      cmd_word;
  logic [15:0]   data_word;
  logic          cmd_start;
  logic          seq_done;
  logic          seq_err;

  logic          ccc_en;
  logic          ccc_valid;
  hdr_frm_kind_e ccc_kind;
  logic [15:0]   ccc_payload;
  logic          ccc_done;
  logic          ccc_ready;

  logic          ddr_en;
  logic          ddr_valid;
  hdr_frm_kind_e ddr_kind;
  logic [15:0]   ddr_payload;
  logic          ddr_done;
  logic          ddr_ready;

  logic          src_valid;
  hdr_frm_kind_e src_kind;
  logic [15:0]   src_payload;
  logic          src_ready;

  apb_hdr_regs u_regs (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_mode      (mode),
    .o_cp        (cp),
    .o_toc       (toc),
    .o_cmd_word  (cmd_word),
    .o_data_word (data_word),
    .o_cmd_start (cmd_start),
    .i_seq_done  (seq_done),
    .i_seq_err   (seq_err),
    .o_irq       (o_irq)
  );

  hdr_engine u_engine (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst_n   (i_sys_rst_n),
    .i_cmd_start   (cmd_start),
    .i_mode        (mode),
    .i_cp          (cp),
    .i_toc         (toc),
    .o_ccc_en      (ccc_en),
    .o_ddr_en      (ddr_en),
    .i_ccc_valid   (ccc_valid),
    .i_ccc_kind    (ccc_kind),
    .i_ccc_payload (ccc_payload),
    .i_ccc_done    (ccc_done),
    .o_ccc_ready   (ccc_ready),
    .i_ddr_valid   (ddr_valid),
    .i_ddr_kind    (ddr_kind),
    .i_ddr_payload (ddr_payload),
    .i_ddr_done    (ddr_done),
    .o_ddr_ready   (ddr_ready),
    .o_src_valid   (src_valid),
    .o_src_kind    (src_kind),
    .o_src_payload (src_payload),
    .i_src_ready   (src_ready),
    .o_seq_done    (seq_done),
    .o_seq_err     (seq_err)
  );

  ccc_frame_gen u_ccc (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst_n   (i_sys_rst_n),
    .i_en          (ccc_en),
    .i_cmd_word    (cmd_word),
    .i_data_word   (data_word),
    .o_frm_valid   (ccc_valid),
    .o_frm_kind    (ccc_kind),
    .o_frm_payload (ccc_payload),
    .i_frm_ready   (ccc_ready),
    .o_gen_done    (ccc_done)
  );

  ddr_frame_gen u_ddr (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst_n   (i_sys_rst_n),
    .i_en          (ddr_en),
    .i_cmd_word    (cmd_word),
    .i_data_word   (data_word),
    .o_frm_valid   (ddr_valid),
    .o_frm_kind    (ddr_kind),
    .o_frm_payload (ddr_payload),
    .i_frm_ready   (ddr_ready),
    .o_gen_done    (ddr_done)
  );

  hdr_frame_out u_out (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst_n   (i_sys_rst_n),
    .i_src_valid   (src_valid),
    .i_src_kind    (src_kind),
    .i_src_payload (src_payload),
    .o_src_ready   (src_ready),
    .o_frm_valid   (o_frm_valid),
    .o_frm_data    (o_frm_data),
    .i_frm_ready   (i_frm_ready)
  );

endmodule

// File: hdl/hdr_frame_out.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDR frame output stage with preamble, parity and PHY back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hdr_macros.svh"

module hdr_frame_out import hdr_pkg::*; (
  input  logic                  i_sys_clk,
  input  logic                  i_sys_rst_n,
  input  logic                  i_src_valid,
  input  hdr_frm_kind_e         i_src_kind,
  input  logic [15:0]           i_src_payload,
  output logic                  o_src_ready,
  output logic                  o_frm_valid,
  output logic [`HDR_FRM_W-1:0] o_frm_data,
  input  logic                  i_frm_ready
);

  logic [1:0]  pre;
  logic [15:0] payload;

  // free, or being drained this cycle
  assign o_src_ready = !o_frm_valid || i_frm_ready;

  always_comb begin
    payload = 16'd0;
    case (i_src_kind)
      FRM_CMD: begin
        pre     = `HDR_PRE_CMD;
        payload = i_src_payload;
      end
      FRM_DATA: begin
        pre     = `HDR_PRE_DATA;
        payload = i_src_payload;
      end
      FRM_EXIT: pre = `HDR_PRE_EXIT;
      default:  pre = `HDR_PRE_RESTART;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_frm_valid <= 1'b0;
    end else if (i_src_valid && o_src_ready) begin
      o_frm_valid <= 1'b1;
    end else if (i_frm_ready) begin
      o_frm_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_src_valid && o_src_ready) begin
      o_frm_data <= {pre, payload, hdr_parity(payload)};
    end
  end

endmodule

// File: hdl/ddr_frame_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDR-DDR frame generator: command frame, plus a data frame on writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ddr_frame_gen import hdr_pkg::*; (
  input  logic          i_sys_clk,
  input  logic          i_sys_rst_n,
  input  logic          i_en,
  input  hdr_cmd_u      i_cmd_word,
  input  logic [15:0]   i_data_word,
  output logic          o_frm_valid,
  output hdr_frm_kind_e o_frm_kind,
  output logic [15:0]   o_frm_payload,
  input  logic          i_frm_ready,
  output logic          o_gen_done
);

  hdr_cmd_u    cmd_q;
  logic [15:0] data_q;
  logic        data_step_q;
  logic        is_write;
  logic        last;

  // read data is not collected here, a read is its command frame only
  assign is_write = !cmd_q.ddr.rnw;
  assign last     = data_step_q || !is_write;

  always_ff @(posedge i_sys_clk) begin
    if (i_en) begin
      cmd_q  <= i_cmd_word;
      data_q <= i_data_word;
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_frm_valid <= 1'b0;
      data_step_q <= 1'b0;
    end else if (i_en) begin
      o_frm_valid <= 1'b1;
      data_step_q <= 1'b0;
    end else if (o_frm_valid && i_frm_ready) begin
      if (last) begin
        o_frm_valid <= 1'b0;
      end
      data_step_q <= !last;
    end
  end

  assign o_frm_kind    = data_step_q ? FRM_DATA : FRM_CMD;
  // command frame passes the word through, reserved bit included
  assign o_frm_payload = data_step_q ? data_q : cmd_q.ddr;
  assign o_gen_done    = o_frm_valid && i_frm_ready && last;

endmodule

// File: hdl/ccc_frame_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CCC frame generator: command frame, plus a data frame for direct CCCs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ccc_frame_gen import hdr_pkg::*; (
  input  logic          i_sys_clk,
  input  logic          i_sys_rst_n,
  input  logic          i_en,
  input  hdr_cmd_u      i_cmd_word,
  input  logic [15:0]   i_data_word,
  output logic          o_frm_valid,
  output hdr_frm_kind_e o_frm_kind,
  output logic [15:0]   o_frm_payload,
  input  logic          i_frm_ready,
  output logic          o_gen_done
);

  hdr_cmd_u    cmd_q;
  logic [7:0]  data_q;
  logic        data_step_q;
  logic        direct;
  logic        last;

  // bit 7 of the code marks a direct CCC
  assign direct = cmd_q.ccc.ccc_code[7];
  assign last   = data_step_q || !direct;

  always_ff @(posedge i_sys_clk) begin
    if (i_en) begin
      cmd_q  <= i_cmd_word;
      data_q <= i_data_word[7:0];
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_frm_valid <= 1'b0;
      data_step_q <= 1'b0;
    end else if (i_en) begin
      o_frm_valid <= 1'b1;
      data_step_q <= 1'b0;
    end else if (o_frm_valid && i_frm_ready) begin
      if (last) begin
        o_frm_valid <= 1'b0;
      end
      data_step_q <= !last;
    end
  end

  assign o_frm_kind    = data_step_q ? FRM_DATA : FRM_CMD;
  // data frame is the defining byte over the low data byte
  assign o_frm_payload = data_step_q ? {cmd_q.ccc.def_byte, data_q}
                                     : {cmd_q.ccc.ccc_code, cmd_q.ccc.def_byte};
  assign o_gen_done    = o_frm_valid && i_frm_ready && last;

endmodule

// File: hdl/hdr_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDR sequencer: launches the CCC or DDR generator, then exit or restart
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hdr_macros.svh"

module hdr_engine import hdr_pkg::*; (
  input  logic          i_sys_clk,
  input  logic          i_sys_rst_n,
  input  logic          i_cmd_start,
  input  logic [2:0]    i_mode,
  input  logic          i_cp,
  input  logic          i_toc,
  output logic          o_ccc_en,
  output logic          o_ddr_en,
  input  logic          i_ccc_valid,
  input  hdr_frm_kind_e i_ccc_kind,
  input  logic [15:0]   i_ccc_payload,
  input  logic          i_ccc_done,
  output logic          o_ccc_ready,
  input  logic          i_ddr_valid,
  input  hdr_frm_kind_e i_ddr_kind,
  input  logic [15:0]   i_ddr_payload,
  input  logic          i_ddr_done,
  output logic          o_ddr_ready,
  output logic          o_src_valid,
  output hdr_frm_kind_e o_src_kind,
  output logic [15:0]   o_src_payload,
  input  logic          i_src_ready,
  output logic          o_seq_done,
  output logic          o_seq_err
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CCC  = 2'd1,
    ST_DDR  = 2'd2,
    ST_TERM = 2'd3
  } state_e;

  // state doubles as the source select
  state_e state_q;
  logic   toc_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state_q    <= ST_IDLE;
      toc_q      <= 1'b0;
      o_ccc_en   <= 1'b0;
      o_ddr_en   <= 1'b0;
      o_seq_done <= 1'b0;
      o_seq_err  <= 1'b0;
    end else begin
      o_ccc_en   <= 1'b0;
      o_ddr_en   <= 1'b0;
      o_seq_done <= 1'b0;
      o_seq_err  <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (i_cmd_start) begin
            toc_q <= i_toc;
            if (i_mode != `HDR_MODE_DDR) begin
              // wrong mode, finish with no frames
              o_seq_done <= 1'b1;
              o_seq_err  <= 1'b1;
            end else if (i_cp) begin
              o_ccc_en <= 1'b1;
              state_q  <= ST_CCC;
            end else begin
              o_ddr_en <= 1'b1;
              state_q  <= ST_DDR;
            end
          end
        end
        ST_CCC: begin
          if (i_ccc_done) begin
            state_q <= ST_TERM;
          end
        end
        ST_DDR: begin
          if (i_ddr_done) begin
            state_q <= ST_TERM;
          end
        end
        ST_TERM: begin
          if (i_src_ready) begin
            o_seq_done <= 1'b1;
            state_q    <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // frame source mux
  always_comb begin
    o_src_valid   = 1'b0;
    o_src_kind    = FRM_CMD;
    o_src_payload = 16'd0;
    case (state_q)
      ST_CCC: begin
        o_src_valid   = i_ccc_valid;
        o_src_kind    = i_ccc_kind;
        o_src_payload = i_ccc_payload;
      end
      ST_DDR: begin
        o_src_valid   = i_ddr_valid;
        o_src_kind    = i_ddr_kind;
        o_src_payload = i_ddr_payload;
      end
      ST_TERM: begin
        o_src_valid = 1'b1;
        o_src_kind  = toc_q ? FRM_EXIT : FRM_RESTART;
      end
      default: ;
    endcase
  end

  assign o_ccc_ready = (state_q == ST_CCC) && i_src_ready;
  assign o_ddr_ready = (state_q == ST_DDR) && i_src_ready;

endmodule

// File: hdl/apb_hdr_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register bank for the HDR controller, command start and status
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hdr_macros.svh"

module apb_hdr_regs import hdr_pkg::*; (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`HDR_APB_AW-1:0] i_paddr,
  input  logic [31:0]            i_pwdata,
  output logic [31:0]            o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr,
  output logic [2:0]             o_mode,
  output logic                   o_cp,
  output logic                   o_toc,
  output hdr_cmd_u               o_cmd_word,
  output logic [15:0]            o_data_word,
  output logic                   o_cmd_start,
  input  logic                   i_seq_done,
  input  logic                   i_seq_err,
  output logic                   o_irq
);

  logic        access;
  logic        wr_en;
  logic        wr_ctrl;
  logic        start_req;
  logic        mapped;
  logic        busy_q;
  logic        done_q;
  logic        err_q;
  logic [31:0] ctrl_rd;
  logic [31:0] stat_rd;

  assign access  = i_psel && i_penable;
  assign wr_en   = access && i_pwrite;
  assign wr_ctrl = wr_en && (i_paddr == `HDR_REG_CTRL);
  // a start while a command runs is dropped
  assign start_req = wr_ctrl && i_pwdata[`HDR_CTRL_START_BIT] && !busy_q;

  assign mapped = (i_paddr == `HDR_REG_CTRL) || (i_paddr == `HDR_REG_CMD) ||
                  (i_paddr == `HDR_REG_DATA) || (i_paddr == `HDR_REG_STATUS);

  // no wait states
  assign o_pready  = 1'b1;
  assign o_pslverr = access && !mapped;
  assign o_irq     = done_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_mode      <= 3'd0;
      o_cp        <= 1'b0;
      o_toc       <= 1'b0;
      o_cmd_start <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      o_cmd_start <= start_req;
      if (wr_ctrl) begin
        o_mode <= i_pwdata[`HDR_CTRL_MODE_LSB +: 3];
        o_cp   <= i_pwdata[`HDR_CTRL_CP_BIT];
        o_toc  <= i_pwdata[`HDR_CTRL_TOC_BIT];
      end
      // sticky status, cleared by the next accepted start
      if (start_req) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
        err_q  <= 1'b0;
      end else if (i_seq_done) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
        err_q  <= i_seq_err;
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (wr_en && (i_paddr == `HDR_REG_CMD)) begin
      o_cmd_word <= i_pwdata[15:0];
    end
    if (wr_en && (i_paddr == `HDR_REG_DATA)) begin
      o_data_word <= i_pwdata[15:0];
    end
  end

  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[`HDR_CTRL_MODE_LSB +: 3] = o_mode;
    ctrl_rd[`HDR_CTRL_CP_BIT]        = o_cp;
    ctrl_rd[`HDR_CTRL_TOC_BIT]       = o_toc;
    stat_rd = '0;
    stat_rd[`HDR_STAT_BUSY_BIT] = busy_q;
    stat_rd[`HDR_STAT_DONE_BIT] = done_q;
    stat_rd[`HDR_STAT_ERR_BIT]  = err_q;
  end

  // read mux
  always_comb begin
    case (i_paddr)
      `HDR_REG_CTRL:   o_prdata = ctrl_rd;
      `HDR_REG_CMD:    o_prdata = {16'd0, o_cmd_word};
      `HDR_REG_DATA:   o_prdata = {16'd0, o_data_word};
      `HDR_REG_STATUS: o_prdata = stat_rd;
      default:         o_prdata = 32'd0;
    endcase
  end

endmodule

// File: hdl/hdr_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDR types: command word views, frame kinds and frame parity
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hdr_pkg;

  // command word seen as a CCC
  typedef struct packed {
    logic [7:0] ccc_code;
    logic [7:0] def_byte;
  } hdr_ccc_view_t;

  // command word seen as an HDR-DDR command
  typedef struct packed {
    logic       rnw;
    logic [6:0] cmd_code;
    logic [6:0] tgt_addr;
    logic       rsvd;
  } hdr_ddr_view_t;

  typedef union packed {
    hdr_ccc_view_t ccc;
    hdr_ddr_view_t ddr;
  } hdr_cmd_u;

  typedef enum logic [1:0] {
    FRM_CMD     = 2'd0,
    FRM_DATA    = 2'd1,
    FRM_EXIT    = 2'd2,
    FRM_RESTART = 2'd3
  } hdr_frm_kind_e;

  // odd bits into [1], even bits inverted into [0]
  function automatic logic [1:0] hdr_parity(input logic [15:0] payload);
    logic [1:0] par;
    par[1] = ^(payload & 16'hAAAA);
    par[0] = ~(^(payload & 16'h5555));
    return par;
  endfunction

endpackage

// File: hdl/hdr_macros.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I3C HDR controller constants: register map, control bits, frame format
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef HDR_MACROS_SVH
`define HDR_MACROS_SVH

`define HDR_MODE_DDR        3'd6

// APB map, byte offsets
`define HDR_APB_AW          4
`define HDR_REG_CTRL        4'h0
`define HDR_REG_CMD         4'h4
`define HDR_REG_DATA        4'h8
`define HDR_REG_STATUS      4'hC

// CTRL fields, START is write-only
`define HDR_CTRL_MODE_LSB   0
`define HDR_CTRL_CP_BIT     3
`define HDR_CTRL_TOC_BIT    4
`define HDR_CTRL_START_BIT  5

`define HDR_STAT_BUSY_BIT   0
`define HDR_STAT_DONE_BIT   1
`define HDR_STAT_ERR_BIT    2

// frame = preamble, payload, parity
`define HDR_PRE_CMD         2'b01
`define HDR_PRE_DATA        2'b10
`define HDR_PRE_EXIT        2'b11
`define HDR_PRE_RESTART     2'b00
`define HDR_FRM_W           20

`endif
